//--- pivot_pkg.sv
package pivot_pkg;

    // word widths
    parameter int ELEM_W = 32;             // one tableau element
    parameter int IDX_W  = ELEM_W / 2;     // row index and row count
    parameter int PROD_W = 2 * ELEM_W;     // exact product of two magnitudes

    // scalar types
    typedef logic signed [ELEM_W-1:0] elem_t;    // signed fixed-point element
    typedef logic        [ELEM_W-1:0] mag_t;     // unsigned, fits |most negative|
    typedef logic        [IDX_W-1:0]  row_idx_t; // row number inside one problem
    typedef logic        [PROD_W-1:0] prod_t;    // cross product, never overflows

    // one row after screening, signs already removed
    typedef struct packed {
        logic     eligible;  // candidate present
        logic     last;      // closes the problem
        row_idx_t idx;       // row number
        mag_t     piv_mag;   // |pivot column entry|
        mag_t     rhs_mag;   // |right-hand entry|
    } cand_t;

    // two candidates for one ratio comparison
    typedef struct packed {
        cand_t a;  // earlier row, wins ties
        cand_t b;  // later row
    } pair_t;

endpackage

//--- row_screen.sv
`timescale 1ns/1ps

module row_screen (
    input  logic                clk,
    input  logic                areset,
    input  pivot_pkg::row_idx_t num_rows,
    input  logic                in_valid,
    input  pivot_pkg::elem_t    in_pivot,
    input  pivot_pkg::elem_t    in_rhs,
    output logic                row_valid,
    output pivot_pkg::cand_t    row
);
    import pivot_pkg::*;

    // two's complement magnitude, the most negative value maps to 2**(ELEM_W-1)
    function automatic mag_t magnitude(elem_t x);
        return x[ELEM_W-1] ? mag_t'(-x) : mag_t'(x);
    endfunction

    row_idx_t cnt;       // row number of the next accepted row
    row_idx_t last_idx;  // num_rows - 1
    logic     in_vld;    // input register holds a row
    row_idx_t in_idx;    // number of the registered row
    logic     in_last;   // registered row closes the problem
    elem_t    in_piv_q;  // registered pivot entry
    elem_t    in_rhs_q;  // registered rhs entry
    cand_t    row_d;     // screened row, next value of row

    assign last_idx = num_rows - row_idx_t'(1);

    // row counter and input strobe
    always_ff @(posedge clk or posedge areset) begin
        if (areset) begin
            cnt    <= '0;
            in_vld <= 1'b0;
        end else begin
            in_vld <= in_valid;
            if (in_valid) begin
                cnt <= (cnt == last_idx) ? '0 : cnt + row_idx_t'(1); // wrap for next problem
            end
        end
    end

    // input register
    always_ff @(posedge clk) begin
        if (in_valid) begin
            in_piv_q <= in_pivot;
            in_rhs_q <= in_rhs;
            in_idx   <= cnt;
            in_last  <= (cnt == last_idx);
        end
    end

    // eligibility: nonzero pivot with the same sign as rhs
    always_comb begin
        row_d.eligible = (in_piv_q != '0) && (in_piv_q[ELEM_W-1] == in_rhs_q[ELEM_W-1]);
        row_d.last     = in_last;
        row_d.idx      = in_idx;
        row_d.piv_mag  = magnitude(in_piv_q);
        row_d.rhs_mag  = magnitude(in_rhs_q);  // zero rhs gives ratio 0
    end

    always_ff @(posedge clk or posedge areset) begin
        if (areset) begin
            row_valid <= 1'b0;
        end else begin
            row_valid <= in_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (in_vld) begin
            row <= row_d;
        end
    end

endmodule

//--- pair_former.sv
`timescale 1ns/1ps

module pair_former (
    input  logic             clk,
    input  logic             areset,
    input  logic             row_valid,
    input  pivot_pkg::cand_t row,
    output logic             pair_valid,
    output pivot_pkg::pair_t pair
);
    import pivot_pkg::*;

    cand_t hold;    // first eligible row of an open pair
    logic  sel;     // 0: next eligible row opens, 1: it completes
    logic  emit;    // a pair leaves this cycle
    logic  open_a;  // row goes into the hold slot
    pair_t pair_d;  // next value of pair

    always_comb begin
        pair_d.a          = hold;
        pair_d.a.eligible = sel;   // empty slot when nothing held
        pair_d.a.last     = 1'b0;
        pair_d.b          = row;   // ineligible last row stays marked empty
        emit   = 1'b0;
        open_a = 1'b0;
        if (row_valid) begin
            if (row.last) begin
                emit = 1'b1;                 // flush, even with nothing eligible
            end else if (row.eligible) begin
                emit   = sel;                // second of the pair
                open_a = ~sel;               // first of the pair
            end
        end
    end

    // alternation toggle
    always_ff @(posedge clk or posedge areset) begin
        if (areset) begin
            sel <= 1'b0;
        end else if (row_valid) begin
            if (row.last) begin
                sel <= 1'b0;                 // next problem starts clean
            end else if (row.eligible) begin
                sel <= ~sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (open_a) begin
            hold <= row;
        end
    end

    always_ff @(posedge clk or posedge areset) begin
        if (areset) begin
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= emit;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            pair <= pair_d;
        end
    end

endmodule

//--- ratio_compare.sv
`timescale 1ns/1ps

module ratio_compare #(
    parameter int MULT_STAGES = 2
) (
    input  logic             clk,
    input  logic             areset,
    input  logic             pair_valid,
    input  pivot_pkg::pair_t pair,
    output logic             win_valid,
    output pivot_pkg::cand_t win
);
    import pivot_pkg::*;

    // pair plus both cross products, one pipeline slot
    typedef struct packed {
        pair_t pr;
        prod_t prod_b;  // b.rhs * a.piv, scaled ratio of b
        prod_t prod_a;  // a.rhs * b.piv, scaled ratio of a
    } xprod_t;

    // smaller ratio wins, a keeps ties
    function automatic cand_t pick_smaller(xprod_t x);
        cand_t w;
        if (x.pr.a.eligible && x.pr.b.eligible) begin
            w = (x.prod_b < x.prod_a) ? x.pr.b : x.pr.a;  // strict, lower index on tie
        end else if (x.pr.b.eligible) begin
            w = x.pr.b;
        end else begin
            w = x.pr.a;  // a, or neither: eligible stays low
        end
        w.last = x.pr.a.last | x.pr.b.last;  // end of problem follows the winner
        return w;
    endfunction

    xprod_t xin;

    always_comb begin
        xin.pr     = pair;
        xin.prod_b = prod_t'(pair.b.rhs_mag) * prod_t'(pair.a.piv_mag);
        xin.prod_a = prod_t'(pair.a.rhs_mag) * prod_t'(pair.b.piv_mag);
    end

    generate
        if (MULT_STAGES == 0) begin : g_comb
            // single-cycle compare for the running best
            assign win_valid = pair_valid;
            assign win       = pick_smaller(xin);
        end else begin : g_pipe
            xprod_t                 pipe [MULT_STAGES];  // multiplier pipeline
            logic [MULT_STAGES-1:0] vld_sr;              // matching valid shift

            always_ff @(posedge clk or posedge areset) begin
                if (areset) begin
                    vld_sr    <= '0;
                    win_valid <= 1'b0;
                end else begin
                    vld_sr[0] <= pair_valid;
                    for (int i = 1; i < MULT_STAGES; i++) begin
                        vld_sr[i] <= vld_sr[i-1];
                    end
                    win_valid <= vld_sr[MULT_STAGES-1];
                end
            end

            // payload shifts every cycle, several pairs in flight
            always_ff @(posedge clk) begin
                pipe[0] <= xin;
                for (int i = 1; i < MULT_STAGES; i++) begin
                    pipe[i] <= pipe[i-1];
                end
                win <= pick_smaller(pipe[MULT_STAGES-1]);  // output register
            end
        end
    endgenerate

endmodule

//--- best_row_tracker.sv
`timescale 1ns/1ps

module best_row_tracker (
    input  logic                clk,
    input  logic                areset,
    input  logic                win_valid,
    input  pivot_pkg::cand_t    win,
    output logic                done,
    output logic                found,
    output pivot_pkg::row_idx_t pivot_row
);
    import pivot_pkg::*;

    cand_t best;       // running best of this problem, empty when not eligible
    pair_t cmp_pair;   // held best vs incoming winner
    logic  cmp_valid;  // same cycle as win_valid
    cand_t cmp_win;    // new best

    // held best is the earlier rows, so it goes into slot a
    always_comb begin
        cmp_pair.a = best;
        cmp_pair.b = win;
    end

    ratio_compare #(
        .MULT_STAGES (0)
    ) cmp_i (
        .clk        (clk),
        .areset     (areset),
        .pair_valid (win_valid),
        .pair       (cmp_pair),
        .win_valid  (cmp_valid),
        .win        (cmp_win)
    );

    always_ff @(posedge clk or posedge areset) begin
        if (areset) begin
            best      <= '0;
            done      <= 1'b0;
            found     <= 1'b0;
            pivot_row <= '0;
        end else begin
            done <= 1'b0;  // single-cycle pulse
            if (cmp_valid) begin
                if (cmp_win.last) begin
                    done      <= 1'b1;
                    found     <= cmp_win.eligible;  // low means unbounded
                    pivot_row <= cmp_win.idx;
                    best      <= '0;                // next problem starts empty
                end else begin
                    best <= cmp_win;
                end
            end
        end
    end

endmodule

//--- pivot_row_select.sv
`timescale 1ns/1ps

module pivot_row_select #(
    parameter int MULT_STAGES = 2
) (
    input  logic                clk,
    input  logic                areset,
    input  pivot_pkg::row_idx_t num_rows,
    input  logic                in_valid,
    input  pivot_pkg::elem_t    in_pivot,
    input  pivot_pkg::elem_t    in_rhs,
    output logic                done,
    output logic                found,
    output pivot_pkg::row_idx_t pivot_row
);
    import pivot_pkg::*;

    logic  row_valid;   // screened row strobe
    cand_t row;
    logic  pair_valid;  // pair strobe
    pair_t pair;
    logic  win_valid;   // pair winner strobe
    cand_t win;

    // register input, number rows, test eligibility
    row_screen screen_i (
        .clk       (clk),
        .areset    (areset),
        .num_rows  (num_rows),
        .in_valid  (in_valid),
        .in_pivot  (in_pivot),
        .in_rhs    (in_rhs),
        .row_valid (row_valid),
        .row       (row)
    );

    // alternate eligible rows into pairs
    pair_former pair_i (
        .clk        (clk),
        .areset     (areset),
        .row_valid  (row_valid),
        .row        (row),
        .pair_valid (pair_valid),
        .pair       (pair)
    );

    // first stage, pipelined cross-multiply
    ratio_compare #(
        .MULT_STAGES (MULT_STAGES)
    ) pair_cmp_i (
        .clk        (clk),
        .areset     (areset),
        .pair_valid (pair_valid),
        .pair       (pair),
        .win_valid  (win_valid),
        .win        (win)
    );

    // second stage, running best
    best_row_tracker best_i (
        .clk       (clk),
        .areset    (areset),
        .win_valid (win_valid),
        .win       (win),
        .done      (done),
        .found     (found),
        .pivot_row (pivot_row)
    );

endmodule

//--- tb_pivot_row_select.sv
`timescale 1ns/1ps

module tb_pivot_row_select;
    import pivot_pkg::*;

    localparam int MULT_STAGES  = 2;
    localparam int LATENCY      = MULT_STAGES + 4;  // in_valid edge to done
    localparam int MAX_ROWS     = 20;
    localparam int MAX_GAP      = 3;                // idle cycles between rows
    localparam int MAX_IDLE     = 2;                // idle cycles between problems
    localparam int NUM_PROBLEMS = 101;
    localparam int WATCHDOG_CYCLES =
        NUM_PROBLEMS * (MAX_ROWS * (MAX_GAP + 1) + MAX_IDLE) + 200;

    localparam int KIND_RANDOM      = 0;
    localparam int KIND_TIES        = 1;
    localparam int KIND_INELIGIBLE  = 2;
    localparam int KIND_SINGLE_LAST = 3;
    localparam int KIND_EXTREME     = 4;

    // one expected done
    typedef struct packed {
        logic        found;
        row_idx_t    idx;
        logic [31:0] cyc;   // cycle count when done must be seen
        logic [15:0] prob;  // problem number, for error lines
    } expect_t;

    logic     clk;
    logic     areset;
    row_idx_t num_rows;
    logic     in_valid;
    elem_t    in_pivot;
    elem_t    in_rhs;
    logic     done;
    logic     found;
    row_idx_t pivot_row;

    elem_t       piv_a [MAX_ROWS];  // rows of the current problem
    elem_t       rhs_a [MAX_ROWS];
    expect_t     exp_q [$];         // outstanding results, oldest first
    expect_t     got_e;
    logic [31:0] cyc_cnt = '0;
    logic [15:0] prob_cnt = '0;
    int          checks = 0;
    int          mismatches = 0;
    int          other_errors = 0;
    int          drain;

    pivot_row_select #(
        .MULT_STAGES (MULT_STAGES)
    ) dut_i (
        .clk       (clk),
        .areset    (areset),
        .num_rows  (num_rows),
        .in_valid  (in_valid),
        .in_pivot  (in_pivot),
        .in_rhs    (in_rhs),
        .done      (done),
        .found     (found),
        .pivot_row (pivot_row)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc_cnt <= cyc_cnt + 32'd1;

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($urandom % 32'(hi - lo + 1));
    endfunction

    // mix of zero, small, full range and the two ends
    function automatic elem_t rand_elem();
        case (rand_range(0, 7))
            0:       return '0;
            1:       return 32'sh8000_0000;
            2:       return 32'sh7fff_ffff;
            3, 4:    return elem_t'(rand_range(-1000, 1000));
            default: return elem_t'($urandom);
        endcase
    endfunction

    function automatic elem_t extreme_elem();
        case (rand_range(0, 5))
            0:       return 32'sh8000_0000;
            1:       return 32'sh7fff_ffff;
            2:       return 32'sh8000_0001;
            3:       return elem_t'(1);
            4:       return elem_t'(-1);
            default: return '0;
        endcase
    endfunction

    // zero pivot, or pivot and rhs on opposite sides of zero
    task automatic make_ineligible(output elem_t p, output elem_t r);
        case (rand_range(0, 2))
            0: begin
                p = '0;
                r = rand_elem();
            end
            1: begin
                p = elem_t'(rand_range(1, 1 << 20));
                r = elem_t'(-rand_range(1, 1 << 20));
            end
            default: begin
                p = elem_t'(-rand_range(1, 1 << 20));
                r = elem_t'(rand_range(0, 1 << 20));  // zero rhs counts as positive
            end
        endcase
    endtask

    task automatic gen_rows(input int kind, input int n);
        int base_p;
        int base_r;
        int k;
        int s;
        base_p = rand_range(1, 1 << 16);
        base_r = rand_range(1, 1 << 16);
        for (int i = 0; i < n; i++) begin
            s = (rand_range(0, 1) == 1) ? -1 : 1;
            case (kind)
                KIND_TIES: begin
                    if (rand_range(0, 3) == 0) begin
                        make_ineligible(piv_a[i], rhs_a[i]);
                    end else begin
                        k        = rand_range(1, 8);     // scaled copy, same ratio
                        piv_a[i] = elem_t'(s * k * base_p);
                        rhs_a[i] = elem_t'(s * k * base_r);
                    end
                end
                KIND_INELIGIBLE: make_ineligible(piv_a[i], rhs_a[i]);
                KIND_SINGLE_LAST: begin
                    if (i < n - 1) begin
                        make_ineligible(piv_a[i], rhs_a[i]);
                    end else begin
                        piv_a[i] = elem_t'(s * rand_range(1, 1000));
                        rhs_a[i] = elem_t'(s * rand_range(1, 1000));
                    end
                end
                KIND_EXTREME: begin
                    piv_a[i] = extreme_elem();
                    rhs_a[i] = extreme_elem();
                end
                default: begin
                    piv_a[i] = rand_elem();
                    rhs_a[i] = rand_elem();
                end
            endcase
        end
    endtask

    function automatic logic [63:0] mag64(input elem_t x);
        longint v;
        v = longint'(x);  // sign extends
        if (v < 0) v = -v;
        return v;
    endfunction

    function automatic logic row_ok(input elem_t p, input elem_t r);
        return (p != 0) && ((p < 0) == (r < 0));
    endfunction

    // linear scan, strict less keeps the lowest index on ties
    function automatic void model_problem(input int n, output logic f, output row_idx_t idx);
        int          best;
        logic [63:0] cur_x;
        logic [63:0] best_x;
        best = -1;
        for (int i = 0; i < n; i++) begin
            if (row_ok(piv_a[i], rhs_a[i])) begin
                if (best < 0) begin
                    best = i;
                end else begin
                    cur_x  = mag64(rhs_a[i]) * mag64(piv_a[best]);
                    best_x = mag64(rhs_a[best]) * mag64(piv_a[i]);
                    if (cur_x < best_x) best = i;
                end
            end
        end
        f   = (best >= 0);
        idx = (best >= 0) ? row_idx_t'(best) : '0;
    endfunction

    task automatic run_problem(input int kind, input int max_gap);
        int       n;
        int       gap;
        logic     f;
        row_idx_t idx;
        expect_t  e;
        n = (kind == KIND_TIES) ? rand_range(2, MAX_ROWS) : rand_range(1, MAX_ROWS);
        gen_rows(kind, n);
        model_problem(n, f, idx);
        for (int i = 0; i < n; i++) begin
            num_rows = row_idx_t'(n);
            in_valid = 1'b1;
            in_pivot = piv_a[i];
            in_rhs   = rhs_a[i];
            if (i == n - 1) begin
                e.found = f;
                e.idx   = idx;
                e.cyc   = cyc_cnt + 32'(LATENCY + 1);  // sampled on the next edge
                e.prob  = prob_cnt;
                exp_q.push_back(e);
                prob_cnt++;
            end
            @(negedge clk);
            gap = (i < n - 1) ? rand_range(0, max_gap) : 0;
            if (gap > 0) begin
                in_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
        end
    endtask

    task automatic run_batch(input int kind, input int count, input int max_gap,
                             input int max_idle);
        int idle;
        for (int p = 0; p < count; p++) begin
            run_problem(kind, max_gap);
            in_valid = 1'b0;
            idle     = rand_range(0, max_idle);
            repeat (idle) @(negedge clk);
        end
    endtask

    // result check, outputs settled since the rising edge
    always @(negedge clk) begin
        if (!areset && done) begin
            assert (exp_q.size() != 0) else begin
                other_errors++;
                $display("ERROR: done pulsed at cycle %0d with no problem outstanding", cyc_cnt);
            end
            if (exp_q.size() != 0) begin
                got_e = exp_q.pop_front();
                checks++;
                assert (found == got_e.found) else begin
                    mismatches++;
                    $display("MISMATCH found (problem %0d): got %h expected %h",
                             got_e.prob, found, got_e.found);
                end
                if (got_e.found) begin
                    assert (pivot_row == got_e.idx) else begin
                        mismatches++;
                        $display("MISMATCH pivot_row (problem %0d): got %h expected %h",
                                 got_e.prob, pivot_row, got_e.idx);
                    end
                end
                assert (cyc_cnt == got_e.cyc) else begin
                    other_errors++;
                    $display("ERROR: done for problem %0d came at cycle %0d, expected cycle %0d",
                             got_e.prob, cyc_cnt, got_e.cyc);
                end
            end
        end
    end

    // hard limit on run length
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: simulation ran past %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        areset   = 1'b1;
        num_rows = '0;
        in_valid = 1'b0;
        in_pivot = '0;
        in_rhs   = '0;
        void'($urandom(66352));
        repeat (2) @(posedge clk);
        @(negedge clk);
        areset = 1'b0;
        @(negedge clk);

        run_batch(KIND_RANDOM,      40, MAX_GAP, MAX_IDLE);
        run_batch(KIND_TIES,        10, MAX_GAP, MAX_IDLE);
        run_batch(KIND_INELIGIBLE,   8, 2,       1);
        run_batch(KIND_SINGLE_LAST,  8, MAX_GAP, MAX_IDLE);
        run_batch(KIND_EXTREME,     15, 0,       0);  // back to back, no idle
        run_batch(KIND_RANDOM,      20, 0,       0);

        drain = 0;
        while (exp_q.size() != 0 && drain < 4 * LATENCY) begin
            @(negedge clk);
            drain++;
        end
        repeat (LATENCY) @(negedge clk);  // catch a stray done
        assert (exp_q.size() == 0) else begin
            other_errors++;
            $display("ERROR: %0d problems never produced done", exp_q.size());
        end

        $display("done checks: %0d, mismatches: %0d, other errors: %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
pivot_pkg.sv
row_screen.sv
pair_former.sv
ratio_compare.sv
best_row_tracker.sv
pivot_row_select.sv
tb_pivot_row_select.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the pivot row select testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f files.f \
    --top-module tb_pivot_row_select

./obj_dir/Vtb_pivot_row_select > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

echo "simulation passed"
exit 0
